//--- files.f
+incdir+tb
logic/bp_pkg.sv
logic/branch_target_buffer.sv
logic/tournament_predictor.sv
logic/branch_info_stack.sv
logic/fetch_predict_unit.sv
tb/fetch_predict_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch prediction testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module fetch_predict_tb -o fetch_predict_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/fetch_predict_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0

//--- tb/fetch_predict_tasks.svh
`ifndef FETCH_PREDICT_TASKS_SVH
`define FETCH_PREDICT_TASKS_SVH

task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error: %s is %h, expected %h", name, actual, expected);
        report_failure();
    end
endtask

function automatic pc_t rand_pc();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state & 32'hffff_fffc;
endfunction

task automatic idle();
    step(1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
endtask

task automatic fetch(input pc_t pc);
    step(1'b1, pc, 1'b0, '0, '0, 1'b0, 1'b0);
endtask

task automatic fill(input pc_t pc, input pc_t target);
    step(1'b0, '0, 1'b1, pc, target, 1'b0, 1'b0);
endtask

task automatic resolve(input logic taken);
    step(1'b0, '0, 1'b0, '0, '0, 1'b1, taken);
endtask

task automatic fetch_resolve(input pc_t pc, input logic taken);
    step(1'b1, pc, 1'b0, '0, '0, 1'b1, taken);
endtask

task automatic wait_fetch_ready();
    int cycles;
    cycles = 0;
    idle();
    while (!seen_ready && cycles < 10) begin
        idle();
        cycles++;
    end
    if (!seen_ready) begin
        $display("Timed out waiting for fetch_ready to rise");
        report_failure();
    end
endtask

// Resolve every branch in flight with the same outcome
task automatic drain(input logic taken);
    int cycles;
    cycles = 0;
    while (stack_pc.size() != 0 && cycles <= STACK_DEPTH) begin
        resolve(taken);
        cycles++;
    end
    if (stack_pc.size() != 0) begin
        $display("Branch stack did not empty after %0d resolves", cycles);
        report_failure();
    end
endtask

task automatic test_after_reset();
    idle();
    check("fetch_ready", 32'(seen_ready), 32'h1);
    repeat (4) begin
        fetch(rand_pc());
        check("slot_branch", 32'(seen_branch), 32'h0);
        check("slot_taken", 32'(seen_taken), 32'h0);
    end
    resolve(1'b1);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h0);
endtask

task automatic test_btb_fill();
    pc_t pc_a;
    pc_t pc_b;
    pc_t target_b;
    pc_a = rand_pc();
    pc_b = pc_a + 32'h1008;
    target_b = rand_pc();
    // A fetch in the fill cycle still misses
    step(1'b1, pc_a, 1'b1, pc_a, pc_a + 32'h40, 1'b0, 1'b0);
    check("slot_branch", 32'(seen_branch), 32'h0);
    fill(pc_b, target_b);
    wait_fetch_ready();
    fetch(pc_a);
    check("slot_branch", 32'(seen_branch), 32'h1);
    check("slot_target[0]", seen_target[0], pc_a + 32'h40);
    drain(1'b0);
    fetch(pc_a - 32'h4);
    check("slot_branch", 32'(seen_branch), 32'h2);
    check("slot_target[1]", seen_target[1], pc_a + 32'h40);
    drain(1'b0);
    fetch(pc_b);
    check("slot_target[0]", seen_target[0], target_b);
    drain(1'b0);
    // Same index with a different tag
    fetch(pc_a ^ 32'h100);
    check("slot_branch", 32'(seen_branch), 32'h0);
endtask

task automatic test_training();
    pc_t branch_pc;
    branch_pc = rand_pc();
    fill(branch_pc, branch_pc + 32'h80);
    wait_fetch_ready();
    fetch(branch_pc);
    resolve(1'b1);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h1);
    // The second taken resolve already steers a fetch in the same cycle
    fetch(branch_pc);
    fetch_resolve(branch_pc, 1'b1);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h1);
    check("slot_taken[0]", 32'(seen_taken[0]), 32'h1);
    fetch(branch_pc);
    check("slot_taken[0]", 32'(seen_taken[0]), 32'h1);
    drain(1'b1);
    // Alternating outcomes push the chooser toward gshare
    for (int i = 0; i < 12; i++) begin
        fetch(branch_pc);
        drain((i % 2) == 1);
    end
endtask

task automatic test_slot_kill();
    pc_t kill_pc;
    int  tries;
    kill_pc = rand_pc();
    fill(kill_pc, rand_pc());
    fill(kill_pc + 32'h4, rand_pc());
    wait_fetch_ready();
    tries = 0;
    fetch(kill_pc);
    while (!seen_taken[0] && tries < 16) begin
        drain(1'b1);
        fetch(kill_pc);
        tries++;
    end
    if (!seen_taken[0]) begin
        $display("Slot 0 never became predicted taken");
        report_failure();
    end
    check("slot_branch", 32'(seen_branch), 32'h1);
    resolve(1'b1);
    // The killed slot 1 never entered the stack so this resolve finds it empty
    resolve(1'b1);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h0);
    tries = 0;
    fetch(kill_pc);
    while (seen_taken[0] && tries < 16) begin
        drain(1'b0);
        fetch(kill_pc);
        tries++;
    end
    if (seen_taken[0]) begin
        $display("Slot 0 never became predicted not taken");
        report_failure();
    end
    check("slot_branch", 32'(seen_branch), 32'h3);
    resolve(stack_flags[0][0]);
    resolve(stack_flags[0][0]);
    resolve(1'b1);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h0);
    test_backpressure_at(kill_pc);
endtask

task automatic test_backpressure_at(input pc_t pc);
    int tries;
    tries = 0;
    idle();
    while (seen_ready && tries < 8) begin
        fetch(pc);
        tries++;
    end
    if (seen_ready) begin
        $display("fetch_ready never dropped while the stack filled");
        report_failure();
    end
    // Held bundles are not accepted and change nothing
    repeat (3) begin
        fetch(pc);
        check("fetch_ready", 32'(seen_ready), 32'h0);
    end
    resolve(!stack_flags[0][0]);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h1);
    idle();
    check("fetch_ready", 32'(seen_ready), 32'h1);
    resolve(1'b1);
    check("resolve_mispredict", 32'(seen_mispredict), 32'h0);
endtask

task automatic test_backpressure();
    pc_t pair_pc;
    pair_pc = rand_pc();
    fill(pair_pc, rand_pc());
    fill(pair_pc + 32'h4, rand_pc());
    wait_fetch_ready();
    test_backpressure_at(pair_pc);
endtask

`endif

//--- tb/fetch_predict_tb.sv
`default_nettype none

module fetch_predict_tb
    import bp_pkg::*;
();

    logic clock;
    logic reset;
    logic fetch_valid;
    pc_t  fetch_pc;
    logic fetch_ready;
    logic [FETCH_WIDTH-1:0] slot_branch;
    logic [FETCH_WIDTH-1:0] slot_taken;
    pc_t  slot_target [FETCH_WIDTH];
    logic btb_fill_valid;
    pc_t  btb_fill_pc;
    pc_t  btb_fill_target;
    logic resolve_valid;
    logic resolve_taken;
    logic resolve_mispredict;

    // Reference model of the tables, the history and the BTB
    counter_t model_gshare [PHT_SIZE];
    counter_t model_simple [PHT_SIZE];
    counter_t model_chooser [PHT_SIZE];
    history_t model_history;
    logic     model_btb_valid [BTB_ENTRIES];
    pc_t      model_btb_pc [BTB_ENTRIES];
    pc_t      model_btb_target [BTB_ENTRIES];

    // Snapshot stack, oldest in front, flags are {gshare, bimodal, final}
    pc_t        stack_pc [$];
    history_t   stack_history [$];
    logic [2:0] stack_flags [$];

    // Expected slot values of the current bundle
    logic [FETCH_WIDTH-1:0] exp_branch;
    logic [FETCH_WIDTH-1:0] exp_taken;
    logic [FETCH_WIDTH-1:0] exp_gshare;
    logic [FETCH_WIDTH-1:0] exp_simple;
    history_t exp_history [FETCH_WIDTH];
    pc_t      exp_pc [FETCH_WIDTH];
    pc_t      exp_target [FETCH_WIDTH];

    // DUT outputs seen in the last driven cycle
    logic seen_ready;
    logic seen_mispredict;
    logic [FETCH_WIDTH-1:0] seen_branch;
    logic [FETCH_WIDTH-1:0] seen_taken;
    pc_t  seen_target [FETCH_WIDTH];

    logic [31:0] lcg_state;

    fetch_predict_unit DUT (
        .clock              (clock),
        .reset              (reset),
        .fetch_valid        (fetch_valid),
        .fetch_pc           (fetch_pc),
        .fetch_ready        (fetch_ready),
        .slot_branch        (slot_branch),
        .slot_taken         (slot_taken),
        .slot_target        (slot_target),
        .btb_fill_valid     (btb_fill_valid),
        .btb_fill_pc        (btb_fill_pc),
        .btb_fill_target    (btb_fill_target),
        .resolve_valid      (resolve_valid),
        .resolve_taken      (resolve_taken),
        .resolve_mispredict (resolve_mispredict)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic counter_t saturate_toward(input counter_t value, input logic up);
        if (up) begin
            return (value == 2'd3) ? value : value + 2'd1;
        end
        return (value == 2'd0) ? value : value - 2'd1;
    endfunction

    // Train all three tables at the indexes the branch saw when predicted
    function automatic void train_model(input pc_t pc, input history_t hist,
                                        input logic [2:0] flags, input logic taken);
        pht_idx_t simple_idx;
        pht_idx_t gshare_idx;
        logic     gshare_right;
        logic     simple_right;
        simple_idx = pc[HISTORY_BITS+1:2];
        gshare_idx = simple_idx ^ hist;
        gshare_right = (flags[2] == taken);
        simple_right = (flags[1] == taken);
        model_gshare[gshare_idx] = saturate_toward(model_gshare[gshare_idx], taken);
        model_simple[simple_idx] = saturate_toward(model_simple[simple_idx], taken);
        if (gshare_right && !simple_right) begin
            model_chooser[simple_idx] = saturate_toward(model_chooser[simple_idx], 1'b1);
        end else if (simple_right && !gshare_right) begin
            model_chooser[simple_idx] = saturate_toward(model_chooser[simple_idx], 1'b0);
        end
    endfunction

    function automatic void predict_bundle(input pc_t pc);
        history_t hist;
        logic     alive;
        logic     hit;
        btb_idx_t btb_idx;
        pht_idx_t simple_idx;
        hist = model_history;
        alive = 1'b1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            exp_pc[i] = pc + pc_t'(4 * i);
            btb_idx = exp_pc[i][BTB_INDEX_BITS+1:2];
            hit = model_btb_valid[btb_idx]
                && (model_btb_pc[btb_idx][31:BTB_INDEX_BITS+2] == exp_pc[i][31:BTB_INDEX_BITS+2]);
            simple_idx = exp_pc[i][HISTORY_BITS+1:2];
            exp_history[i] = hist;
            exp_target[i] = model_btb_target[btb_idx];
            exp_gshare[i] = model_gshare[simple_idx ^ hist][1];
            exp_simple[i] = model_simple[simple_idx][1];
            exp_branch[i] = hit && alive;
            exp_taken[i] = exp_branch[i]
                && (model_chooser[simple_idx][1] ? exp_gshare[i] : exp_simple[i]);
            if (exp_taken[i]) begin
                alive = 1'b0;
            end
            // Earlier hits still in the bundle were predicted not taken
            if (hit) begin
                hist = {hist[HISTORY_BITS-2:0], 1'b0};
            end
        end
    endfunction

    // One clock cycle: drive, compare with the model, then advance the model
    task automatic step(input logic fv, input pc_t pc, input logic fill_v, input pc_t fill_pc,
                        input pc_t fill_tgt, input logic rv, input logic rt);
        logic     exp_ready;
        logic     exp_mis;
        logic     had_entry;
        logic     fire;
        history_t old_hist;
        btb_idx_t fill_idx;
        @(negedge clock);
        fetch_valid = fv;
        fetch_pc = pc;
        btb_fill_valid = fill_v;
        btb_fill_pc = fill_pc;
        btb_fill_target = fill_tgt;
        resolve_valid = rv;
        resolve_taken = rt;
        #1;
        exp_ready = (STACK_DEPTH - stack_pc.size()) >= FETCH_WIDTH;
        had_entry = rv && (stack_pc.size() != 0);
        exp_mis = 1'b0;
        old_hist = '0;
        // Same-cycle fetch sees trained tables but the old history
        if (had_entry) begin
            old_hist = stack_history[0];
            exp_mis = (rt != stack_flags[0][0]);
            train_model(stack_pc[0], old_hist, stack_flags[0], rt);
        end
        predict_bundle(pc);
        seen_ready = fetch_ready;
        seen_mispredict = resolve_mispredict;
        seen_branch = slot_branch;
        seen_taken = slot_taken;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            seen_target[i] = slot_target[i];
        end
        check("fetch_ready", 32'(fetch_ready), 32'(exp_ready));
        check("resolve_mispredict", 32'(resolve_mispredict), 32'(exp_mis));
        check("slot_branch", 32'(slot_branch), 32'(exp_branch));
        check("slot_taken", 32'(slot_taken), 32'(exp_taken));
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (exp_branch[i]) begin
                check($sformatf("slot_target[%0d]", i), slot_target[i], exp_target[i]);
            end
        end
        fire = fv && exp_ready;
        if (exp_mis) begin
            model_history = {old_hist[HISTORY_BITS-2:0], rt};
            stack_pc.delete();
            stack_history.delete();
            stack_flags.delete();
        end else begin
            if (had_entry) begin
                void'(stack_pc.pop_front());
                void'(stack_history.pop_front());
                void'(stack_flags.pop_front());
            end
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (fire && exp_branch[i]) begin
                    model_history = {exp_history[i][HISTORY_BITS-2:0], exp_taken[i]};
                    stack_pc.push_back(exp_pc[i]);
                    stack_history.push_back(exp_history[i]);
                    stack_flags.push_back({exp_gshare[i], exp_simple[i], exp_taken[i]});
                end
            end
        end
        // A fill becomes visible from the next cycle on
        if (fill_v) begin
            fill_idx = fill_pc[BTB_INDEX_BITS+1:2];
            model_btb_valid[fill_idx] = 1'b1;
            model_btb_pc[fill_idx] = fill_pc;
            model_btb_target[fill_idx] = fill_tgt;
        end
    endtask

    task automatic report_failure();
        $display("Testbench failed");
        $fatal(1, "Stopping at the first error");
    endtask

    `include "fetch_predict_tasks.svh"

    initial begin
        fetch_valid = 1'b0;
        fetch_pc = '0;
        btb_fill_valid = 1'b0;
        btb_fill_pc = '0;
        btb_fill_target = '0;
        resolve_valid = 1'b0;
        resolve_taken = 1'b0;
        reset = 1'b1;
        lcg_state = 32'h29f5_f17e;
        model_history = '0;
        for (int i = 0; i < PHT_SIZE; i++) begin
            model_gshare[i] = '0;
            model_simple[i] = '0;
            model_chooser[i] = '0;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            model_btb_valid[i] = 1'b0;
            model_btb_pc[i] = '0;
            model_btb_target[i] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_after_reset();
        test_btb_fill();
        test_training();
        test_slot_kill();
        test_backpressure();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fetch_predict_unit.sv
`default_nettype none

module fetch_predict_unit
    import bp_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,

    // Fetch bundle handshake and per-slot prediction
    input  wire logic fetch_valid,
    input  wire pc_t  fetch_pc,
    output logic      fetch_ready,
    output logic [FETCH_WIDTH-1:0] slot_branch,
    output logic [FETCH_WIDTH-1:0] slot_taken,
    output pc_t       slot_target [FETCH_WIDTH],

    // BTB fill strobe
    input  wire logic btb_fill_valid,
    input  wire pc_t  btb_fill_pc,
    input  wire pc_t  btb_fill_target,

    // In-order resolve strobe
    input  wire logic resolve_valid,
    input  wire logic resolve_taken,
    output logic      resolve_mispredict
);

    pc_t      slot_pc [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] btb_hit;
    logic     bundle_fire;

    logic [FETCH_WIDTH-1:0] branch_kept;
    logic [FETCH_WIDTH-1:0] pred_taken;
    logic [FETCH_WIDTH-1:0] gshare_taken;
    logic [FETCH_WIDTH-1:0] simple_taken;
    history_t slot_history [FETCH_WIDTH];

    logic     old_valid;
    pc_t      old_pc;
    history_t old_history;
    logic     old_gshare_taken;
    logic     old_simple_taken;
    logic     old_pred_taken;

    // Sequential words of the bundle
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_pc[i] = fetch_pc + pc_t'(4 * i);
        end
    end

    assign bundle_fire = fetch_valid && fetch_ready;
    assign slot_branch = branch_kept;
    assign slot_taken = pred_taken;

    branch_target_buffer btb (
        .clock       (clock),
        .reset       (reset),
        .lookup_pc   (slot_pc),
        .btb_hit     (btb_hit),
        .btb_target  (slot_target),
        .fill_valid  (btb_fill_valid),
        .fill_pc     (btb_fill_pc),
        .fill_target (btb_fill_target)
    );

    tournament_predictor predictor (
        .clock              (clock),
        .reset              (reset),
        .slot_pc            (slot_pc),
        .btb_hit            (btb_hit),
        .bundle_fire        (bundle_fire),
        .branch_kept        (branch_kept),
        .pred_taken         (pred_taken),
        .gshare_taken       (gshare_taken),
        .simple_taken       (simple_taken),
        .slot_history       (slot_history),
        .resolve_valid      (resolve_valid),
        .resolve_taken      (resolve_taken),
        .old_valid          (old_valid),
        .old_pc             (old_pc),
        .old_history        (old_history),
        .old_gshare_taken   (old_gshare_taken),
        .old_simple_taken   (old_simple_taken),
        .old_pred_taken     (old_pred_taken),
        .resolve_mispredict (resolve_mispredict)
    );

    branch_info_stack stack (
        .clock              (clock),
        .reset              (reset),
        .push_fire          (bundle_fire),
        .branch_kept        (branch_kept),
        .pred_taken         (pred_taken),
        .gshare_taken       (gshare_taken),
        .simple_taken       (simple_taken),
        .slot_pc            (slot_pc),
        .slot_history       (slot_history),
        .fetch_ready        (fetch_ready),
        .resolve_valid      (resolve_valid),
        .resolve_mispredict (resolve_mispredict),
        .old_valid          (old_valid),
        .old_pc             (old_pc),
        .old_history        (old_history),
        .old_gshare_taken   (old_gshare_taken),
        .old_simple_taken   (old_simple_taken),
        .old_pred_taken     (old_pred_taken)
    );

endmodule

`default_nettype wire

//--- logic/branch_info_stack.sv
`default_nettype none

module branch_info_stack
    import bp_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,

    // Push side, one accepted bundle per cycle
    input  wire logic  push_fire,
    input  wire logic [FETCH_WIDTH-1:0] branch_kept,
    input  wire logic [FETCH_WIDTH-1:0] pred_taken,
    input  wire logic [FETCH_WIDTH-1:0] gshare_taken,
    input  wire logic [FETCH_WIDTH-1:0] simple_taken,
    input  wire pc_t   slot_pc [FETCH_WIDTH],
    input  wire history_t slot_history [FETCH_WIDTH],
    output logic       fetch_ready,

    // Resolve side, always the oldest entry
    input  wire logic  resolve_valid,
    input  wire logic  resolve_mispredict,
    output logic       old_valid,
    output pc_t        old_pc,
    output history_t   old_history,
    output logic       old_gshare_taken,
    output logic       old_simple_taken,
    output logic       old_pred_taken
);

    pc_t        ent_pc [STACK_DEPTH];
    history_t   ent_history [STACK_DEPTH];
    logic [STACK_DEPTH-1:0] ent_gshare;
    logic [STACK_DEPTH-1:0] ent_simple;
    logic [STACK_DEPTH-1:0] ent_pred;

    stack_ptr_t   head;
    stack_ptr_t   tail;
    stack_ptr_t   tail_next;
    stack_count_t count;
    stack_count_t push_count;
    stack_ptr_t   write_ptr [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] write_en;
    logic         pop;

    // Kept branches land in consecutive entries, slot order preserved
    // A squash in the same cycle drops the bundle, it is on the wrong path
    always_comb begin
        stack_ptr_t ptr;
        ptr = tail;
        push_count = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            write_en[i] = push_fire && branch_kept[i] && !resolve_mispredict;
            write_ptr[i] = ptr;
            if (write_en[i]) begin
                ptr = ptr + stack_ptr_t'(1);
                push_count = push_count + stack_count_t'(1);
            end
        end
        tail_next = ptr;
    end

    assign old_valid = (count != '0);
    assign pop = resolve_valid && old_valid;

    // Room for a full bundle is required before fetch may proceed
    assign fetch_ready = (stack_count_t'(STACK_DEPTH) - count) >= stack_count_t'(FETCH_WIDTH);

    assign old_pc = ent_pc[head];
    assign old_history = ent_history[head];
    assign old_gshare_taken = ent_gshare[head];
    assign old_simple_taken = ent_simple[head];
    assign old_pred_taken = ent_pred[head];

    always_ff @(posedge clock) begin
        if (reset || resolve_mispredict) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= head + stack_ptr_t'(pop);
            tail <= tail_next;
            count <= count + push_count - stack_count_t'(pop);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (write_en[i]) begin
                ent_pc[write_ptr[i]] <= slot_pc[i];
                ent_history[write_ptr[i]] <= slot_history[i];
                ent_gshare[write_ptr[i]] <= gshare_taken[i];
                ent_simple[write_ptr[i]] <= simple_taken[i];
                ent_pred[write_ptr[i]] <= pred_taken[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tournament_predictor.sv
`default_nettype none

module tournament_predictor
    import bp_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,

    // Fetch side
    input  wire pc_t      slot_pc [FETCH_WIDTH],
    input  wire logic [FETCH_WIDTH-1:0] btb_hit,
    input  wire logic     bundle_fire,
    output logic [FETCH_WIDTH-1:0] branch_kept,
    output logic [FETCH_WIDTH-1:0] pred_taken,
    output logic [FETCH_WIDTH-1:0] gshare_taken,
    output logic [FETCH_WIDTH-1:0] simple_taken,
    output history_t      slot_history [FETCH_WIDTH],

    // Resolve side, oldest snapshot comes back from the stack
    input  wire logic     resolve_valid,
    input  wire logic     resolve_taken,
    input  wire logic     old_valid,
    input  wire pc_t      old_pc,
    input  wire history_t old_history,
    input  wire logic     old_gshare_taken,
    input  wire logic     old_simple_taken,
    input  wire logic     old_pred_taken,
    output logic          resolve_mispredict
);

    counter_t [PHT_SIZE-1:0] gshare_pht;
    counter_t [PHT_SIZE-1:0] simple_pht;
    counter_t [PHT_SIZE-1:0] chooser_pht;
    counter_t [PHT_SIZE-1:0] gshare_next;
    counter_t [PHT_SIZE-1:0] simple_next;
    counter_t [PHT_SIZE-1:0] chooser_next;

    history_t global_history;
    history_t history_next;

    logic     train_en;
    pht_idx_t old_gshare_idx;
    pht_idx_t old_simple_idx;
    logic     gshare_right;
    logic     simple_right;

    // One saturating step toward the given direction
    function automatic counter_t step_counter(counter_t value, logic up);
        counter_t result;
        result = value;
        if (up && value != 2'b11) begin
            result = value + 2'b01;
        end else if (!up && value != 2'b00) begin
            result = value - 2'b01;
        end
        return result;
    endfunction

    // A resolve on an empty stack carries no snapshot and is dropped
    assign train_en = resolve_valid && old_valid;
    assign resolve_mispredict = train_en && (resolve_taken != old_pred_taken);

    // Rebuild the indexes this branch used when it was predicted
    assign old_simple_idx = old_pc[HISTORY_BITS+1:2];
    assign old_gshare_idx = old_pc[HISTORY_BITS+1:2] ^ old_history;

    assign gshare_right = (old_gshare_taken == resolve_taken);
    assign simple_right = (old_simple_taken == resolve_taken);

    // Training, the result is also what a same-cycle fetch looks up
    always_comb begin
        gshare_next = gshare_pht;
        simple_next = simple_pht;
        chooser_next = chooser_pht;
        if (train_en) begin
            gshare_next[old_gshare_idx] = step_counter(gshare_pht[old_gshare_idx], resolve_taken);
            simple_next[old_simple_idx] = step_counter(simple_pht[old_simple_idx], resolve_taken);
            // Chooser only moves when exactly one side got it right
            if (gshare_right && !simple_right) begin
                chooser_next[old_simple_idx] = step_counter(chooser_pht[old_simple_idx], 1'b1);
            end else if (simple_right && !gshare_right) begin
                chooser_next[old_simple_idx] = step_counter(chooser_pht[old_simple_idx], 1'b0);
            end
        end
    end

    // Per-slot prediction in program order
    always_comb begin
        history_t shifted;
        pht_idx_t gshare_idx;
        pht_idx_t simple_idx;
        logic     use_gshare;
        logic     alive;
        shifted = global_history;
        alive = 1'b1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_history[i] = shifted;
            simple_idx = slot_pc[i][HISTORY_BITS+1:2];
            gshare_idx = slot_pc[i][HISTORY_BITS+1:2] ^ shifted;
            gshare_taken[i] = gshare_next[gshare_idx][1];
            simple_taken[i] = simple_next[simple_idx][1];
            use_gshare = chooser_next[simple_idx][1];
            branch_kept[i] = btb_hit[i] && alive;
            pred_taken[i] = branch_kept[i] && (use_gshare ? gshare_taken[i] : simple_taken[i]);
            // Nothing after a taken branch is fetched
            if (pred_taken[i]) begin
                alive = 1'b0;
            end
            // an earlier hit that reaches here was predicted not taken
            if (btb_hit[i]) begin
                shifted = {shifted[HISTORY_BITS-2:0], 1'b0};
            end
        end
    end

    // Bundle end takes the last kept branch, repair overrides it
    always_comb begin
        history_next = global_history;
        if (bundle_fire) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (branch_kept[i]) begin
                    history_next = {slot_history[i][HISTORY_BITS-2:0], pred_taken[i]};
                end
            end
        end
        if (resolve_mispredict) begin
            history_next = {old_history[HISTORY_BITS-2:0], resolve_taken};
        end
    end

    // All counters start strongly not taken, chooser on bimodal
    always_ff @(posedge clock) begin
        if (reset) begin
            gshare_pht <= '0;
            simple_pht <= '0;
            chooser_pht <= '0;
            global_history <= '0;
        end else begin
            gshare_pht <= gshare_next;
            simple_pht <= simple_next;
            chooser_pht <= chooser_next;
            global_history <= history_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer
    import bp_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,

    // Parallel lookup with one address per fetch slot
    input  wire pc_t  lookup_pc [FETCH_WIDTH],
    output logic [FETCH_WIDTH-1:0] btb_hit,
    output pc_t       btb_target [FETCH_WIDTH],

    // Fill from decode when a new branch is found
    input  wire logic fill_valid,
    input  wire pc_t  fill_pc,
    input  wire pc_t  fill_target
);

    logic [BTB_ENTRIES-1:0] entry_valid;
    btb_tag_t               entry_tag [BTB_ENTRIES];
    pc_t                    entry_target [BTB_ENTRIES];

    btb_idx_t fill_idx;
    btb_tag_t fill_tag;

    // Index sits right above the dropped word offset bits
    assign fill_idx = fill_pc[BTB_INDEX_BITS+1:2];
    assign fill_tag = fill_pc[31:BTB_INDEX_BITS+2];

    // Lookup reads only the registered table so a fill shows up a cycle later
    always_comb begin
        btb_idx_t idx;
        btb_tag_t tag;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            idx = lookup_pc[i][BTB_INDEX_BITS+1:2];
            tag = lookup_pc[i][31:BTB_INDEX_BITS+2];
            btb_hit[i] = entry_valid[idx] && (entry_tag[idx] == tag);
            btb_target[i] = entry_target[idx];
        end
    end

    // An entry becomes valid on its first fill
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (fill_valid) begin
            entry_valid[fill_idx] <= 1'b1;
        end
    end

    // Tag and target simply overwrite whatever held this index before
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            entry_tag[fill_idx] <= fill_tag;
            entry_target[fill_idx] <= fill_target;
        end
    end

endmodule

`default_nettype wire

//--- logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Fetch bundle geometry
    localparam int FETCH_WIDTH = 2;

    // Global history length, also the width of every pattern table index
    localparam int HISTORY_BITS = 4;
    localparam int PHT_SIZE = 16;

    // Direct-mapped BTB
    localparam int BTB_ENTRIES = 8;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);

    // Branch snapshots in flight between prediction and resolve
    localparam int STACK_DEPTH = 4;
    localparam int STACK_PTR_BITS = $clog2(STACK_DEPTH);
    localparam int STACK_COUNT_BITS = $clog2(STACK_DEPTH + 1);

    // Instruction address, always word aligned
    typedef logic [31:0] pc_t;

    typedef logic [HISTORY_BITS-1:0] history_t;
    typedef logic [HISTORY_BITS-1:0] pht_idx_t;

    // 2-bit saturating counter, upper bit is the prediction
    typedef logic [1:0] counter_t;

    // BTB index is pc[4:2], tag is the rest above it
    typedef logic [BTB_INDEX_BITS-1:0] btb_idx_t;
    typedef logic [31-BTB_INDEX_BITS-2:0] btb_tag_t;

    // Ring pointers wrap naturally at STACK_DEPTH
    typedef logic [STACK_PTR_BITS-1:0] stack_ptr_t;

    // Occupancy needs one more bit than the pointers to hold a full ring
    typedef logic [STACK_COUNT_BITS-1:0] stack_count_t;

endpackage

`default_nettype wire
